// ==== src/mix_cfg_pkg.sv ====
`default_nettype none

package mix_cfg_pkg;

	// datapath widths
	localparam int SAMPLE_W = 17; // signed sine from the oscillator lut
	localparam int LEVEL_W  = 8;  // env level, osc level, pan, master volume
	localparam int ACC_W    = 48; // products and frame sums
	localparam int OUT_W    = 16; // one audio channel

	// the volume product is scaled back into 16-bit range by this shift
	localparam int OUT_SHIFT = 26;

	// register port
	localparam int ADR_W = 7;

	// field offsets inside each 16-address oscillator block
	localparam logic [3:0] REG_OSC_LVL = 4'd2;
	localparam logic [3:0] REG_OSC_PAN = 4'd7;

	localparam logic [ADR_W-1:0] REG_M_VOL = 7'd1; // common bank

	localparam logic signed [LEVEL_W-1:0] PAN_MAX = 8'sd127; // full right

	typedef enum logic {
		BANK_OSC = 1'b0,
		BANK_COM = 1'b1
	} reg_bank_e;

endpackage

`default_nettype wire

// ==== src/mix_types_pkg.sv ====
`default_nettype none

package mix_types_pkg;

	import mix_cfg_pkg::*;

	// one sample from the envelope and oscillator section
	typedef struct packed {
		logic [1:0]                  osc;  // oscillator index
		logic signed [LEVEL_W-1:0]   lvl;  // envelope level
		logic signed [SAMPLE_W-1:0]  sine;
		logic                        last; // closes the audio frame
	} mix_sample_t;

	// patch view of one oscillator
	typedef struct packed {
		logic signed [LEVEL_W-1:0] lvl;
		logic signed [LEVEL_W-1:0] pan; // 0 .. PAN_MAX
	} osc_patch_t;

	// left and right words of the scaler output and frame sums
	typedef struct packed {
		logic signed [ACC_W-1:0] l;
		logic signed [ACC_W-1:0] r;
	} stereo_t;

endpackage

`default_nettype wire

// ==== src/patch_regs.sv ====
`default_nettype none

module patch_regs
	import mix_cfg_pkg::*, mix_types_pkg::*;
#(
	parameter int OSCS = 4
) (
	input  wire logic                      sCLK_XVXENVS,
	input  wire logic                      reset_data_N,
	input  wire reg_bank_e                 bank,
	input  wire logic [ADR_W-1:0]          adr,
	input  wire logic [LEVEL_W-1:0]        wdata,
	input  wire logic                      write,
	input  wire logic                      read,
	output logic [LEVEL_W-1:0]             rdata,
	output osc_patch_t [OSCS-1:0]          osc_patch,
	output logic signed [LEVEL_W-1:0]      m_vol
);

	logic [ADR_W-5:0]   osc_idx; // upper address bits pick the oscillator
	logic [3:0]         fld;
	logic               osc_hit;
	logic [LEVEL_W-1:0] rd_next;

	assign osc_idx = adr[ADR_W-1:4];
	assign fld     = adr[3:0];
	assign osc_hit = (bank == BANK_OSC) && (int'(osc_idx) < OSCS);

	// register writes
	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			for (int i = 0; i < OSCS; i++) begin
				osc_patch[i].lvl <= (i <= 1) ? 8'sh40 : 8'sh00; // two oscs audible by default
				osc_patch[i].pan <= 8'sh40;                     // centre
			end
			m_vol <= 8'sh40;
		end else if (write) begin
			case (bank)
				BANK_OSC: begin
					if (osc_hit) begin
						case (fld)
							REG_OSC_LVL: osc_patch[osc_idx].lvl <= wdata;
							REG_OSC_PAN: osc_patch[osc_idx].pan <= wdata;
							default: ; // unmapped field
						endcase
					end
				end
				BANK_COM: begin
					if (adr == REG_M_VOL)
						m_vol <= wdata;
				end
				default: ;
			endcase
		end
	end

	// read mux with zero for unmapped reads
	always_comb begin
		rd_next = '0;
		case (bank)
			BANK_OSC: begin
				if (osc_hit) begin
					case (fld)
						REG_OSC_LVL: rd_next = osc_patch[osc_idx].lvl;
						REG_OSC_PAN: rd_next = osc_patch[osc_idx].pan;
						default: rd_next = '0;
					endcase
				end
			end
			BANK_COM: begin
				if (adr == REG_M_VOL)
					rd_next = m_vol;
			end
			default: rd_next = '0;
		endcase
	end

	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N)
			rdata <= '0;
		else if (read)
			rdata <= rd_next; // holds until the next read
	end

endmodule

`default_nettype wire

// ==== src/osc_scaler.sv ====
`default_nettype none

module osc_scaler
	import mix_cfg_pkg::*, mix_types_pkg::*;
#(
	parameter int OSCS = 4
) (
	input  wire logic                 sCLK_XVXENVS,
	input  wire logic                 reset_data_N,
	input  wire logic                 sample_en,
	input  wire mix_sample_t          sample,
	input  wire osc_patch_t [OSCS-1:0] osc_patch,
	output stereo_t                   prod,
	output logic                      prod_en,
	output logic                      prod_last
);

	// stage 1 holds env level times sine
	logic                    s1_v;
	logic [1:0]              s1_osc;
	logic                    s1_last;
	logic signed [ACC_W-1:0] s1_val;

	// stage 2 adds the osc level
	logic                    s2_v;
	logic [1:0]              s2_osc;
	logic                    s2_last;
	logic signed [ACC_W-1:0] s2_val;

	// valid bits travel with the data
	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			s1_v    <= 1'b0;
			s2_v    <= 1'b0;
			prod_en <= 1'b0;
		end else begin
			s1_v    <= sample_en;
			s2_v    <= s1_v;
			prod_en <= s2_v;
		end
	end

	always_ff @(posedge sCLK_XVXENVS) begin
		s1_val  <= sample.lvl * sample.sine;
		s1_osc  <= sample.osc;
		s1_last <= sample.last;

		s2_val  <= s1_val * osc_patch[s1_osc].lvl; // patch entry of this sample's osc
		s2_osc  <= s1_osc;
		s2_last <= s1_last;

		// left gets the pan complement
		prod.l    <= s2_val * (PAN_MAX - osc_patch[s2_osc].pan);
		prod.r    <= s2_val * osc_patch[s2_osc].pan;
		prod_last <= s2_last;
	end

endmodule

`default_nettype wire

// ==== src/frame_mixer.sv ====
`default_nettype none

module frame_mixer
	import mix_cfg_pkg::*, mix_types_pkg::*;
(
	input  wire logic                   sCLK_XVXENVS,
	input  wire logic                   reset_data_N,
	input  wire stereo_t                prod,
	input  wire logic                   prod_en,
	input  wire logic                   prod_last,
	input  wire logic signed [LEVEL_W-1:0] m_vol,
	output logic signed [OUT_W-1:0]     lsound_out,
	output logic signed [OUT_W-1:0]     rsound_out,
	output logic                        out_valid
);

	localparam logic signed [ACC_W-1:0] SAT_HI = ACC_W'(2**(OUT_W-1) - 1);
	localparam logic signed [ACC_W-1:0] SAT_LO = -SAT_HI - 1;

	stereo_t acc;   // running frame sums
	stereo_t fin;   // completed frame
	logic    fin_v;
	stereo_t vol;   // after master volume
	logic    vol_v;

	function automatic logic signed [OUT_W-1:0] sat_out(input logic signed [ACC_W-1:0] v);
		logic signed [ACC_W-1:0] s;
		s = v >>> OUT_SHIFT;
		if (s > SAT_HI)
			return SAT_HI[OUT_W-1:0];
		else if (s < SAT_LO)
			return SAT_LO[OUT_W-1:0];
		return s[OUT_W-1:0];
	endfunction

	// the last product hands the sum on and restarts from zero
	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			acc   <= '0;
			fin_v <= 1'b0;
		end else begin
			fin_v <= prod_en && prod_last;
			if (prod_en && prod_last) begin
				acc <= '0;
			end else if (prod_en) begin
				acc.l <= acc.l + prod.l;
				acc.r <= acc.r + prod.r;
			end
		end
	end

	always_ff @(posedge sCLK_XVXENVS) begin
		fin.l <= acc.l + prod.l;
		fin.r <= acc.r + prod.r;
		vol.l <= fin.l * m_vol;
		vol.r <= fin.r * m_vol;
	end

	// output stage
	always_ff @(posedge sCLK_XVXENVS) begin
		if (!reset_data_N) begin
			vol_v      <= 1'b0;
			out_valid  <= 1'b0;
			lsound_out <= '0;
			rsound_out <= '0;
		end else begin
			vol_v     <= fin_v;
			out_valid <= vol_v; // single cycle per frame
			if (vol_v) begin
				lsound_out <= sat_out(vol.l);
				rsound_out <= sat_out(vol.r);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/fm_mixer_top.sv ====
`default_nettype none

module fm_mixer_top
	import mix_cfg_pkg::*, mix_types_pkg::*;
#(
	parameter int OSCS = 4
) (
	input  wire logic                 sCLK_XVXENVS,
	input  wire logic                 reset_data_N,
	input  wire logic                 sample_en,
	input  wire mix_sample_t          sample,
	input  wire reg_bank_e            bank,
	input  wire logic [ADR_W-1:0]     adr,
	input  wire logic [LEVEL_W-1:0]   wdata,
	input  wire logic                 write,
	input  wire logic                 read,
	output logic [LEVEL_W-1:0]        rdata,
	output logic signed [OUT_W-1:0]   lsound_out,
	output logic signed [OUT_W-1:0]   rsound_out,
	output logic                      out_valid
);

	osc_patch_t [OSCS-1:0]      osc_patch;
	logic signed [LEVEL_W-1:0]  m_vol;
	stereo_t                    prod;
	logic                       prod_en;
	logic                       prod_last;

	patch_regs #(.OSCS(OSCS)) u_regs (
		.sCLK_XVXENVS, .reset_data_N,
		.bank, .adr, .wdata, .write, .read,
		.rdata, .osc_patch, .m_vol
	);

	osc_scaler #(.OSCS(OSCS)) u_scaler (
		.sCLK_XVXENVS, .reset_data_N,
		.sample_en, .sample, .osc_patch,
		.prod, .prod_en, .prod_last
	);

	frame_mixer u_mixer (
		.sCLK_XVXENVS, .reset_data_N,
		.prod, .prod_en, .prod_last, .m_vol,
		.lsound_out, .rsound_out, .out_valid
	);

endmodule

`default_nettype wire

// ==== tests/fm_mixer_chk.sv ====
`default_nettype none

module fm_mixer_chk (
	input wire logic sCLK_XVXENVS,
	input wire logic reset_data_N,
	input wire logic sample_en,
	input wire logic sample_last,
	input wire logic out_valid
);

	logic last_in;

	assign last_in = sample_en && sample_last;

	// reset clears the output pipeline
	a_reset_quiet: assert property (@(posedge sCLK_XVXENVS)
		!reset_data_N |=> !out_valid)
		else $error("out_valid high after a reset cycle");

	// out_valid is sampled one edge after it rises
	a_latency: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_data_N)
		last_in |-> ##6 out_valid)
		else $error("out_valid missing 5 cycles after a last sample");

	a_no_spurious: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_data_N)
		$rose(out_valid) |-> $past(last_in, 6))
		else $error("out_valid without a matching last sample");

	a_pulse: assert property (@(posedge sCLK_XVXENVS) disable iff (!reset_data_N)
		(out_valid && $past(out_valid)) |-> ($past(last_in, 6) && $past(last_in, 7)))
		else $error("out_valid held for two cycles");

endmodule

bind fm_mixer_top fm_mixer_chk u_chk (
	.sCLK_XVXENVS(sCLK_XVXENVS),
	.reset_data_N(reset_data_N),
	.sample_en(sample_en),
	.sample_last(sample.last),
	.out_valid(out_valid)
);

`default_nettype wire

// ==== tests/tb_fm_mixer.sv ====
`default_nettype none

module tb_fm_mixer
	import mix_cfg_pkg::*, mix_types_pkg::*;
;

	logic               sCLK_XVXENVS;
	logic               reset_data_N;
	logic               sample_en;
	mix_sample_t        sample;
	reg_bank_e          bank;
	logic [ADR_W-1:0]   adr;
	logic [LEVEL_W-1:0] wdata;
	logic               write;
	logic               read;
	logic [LEVEL_W-1:0] rdata;
	logic signed [OUT_W-1:0] lsound_out;
	logic signed [OUT_W-1:0] rsound_out;
	logic               out_valid;

	int cyc;
	int err_mismatch;
	int err_timeout;
	logic [16:0] lfsr_state;

	int sh_lvl[4]; // values the testbench wrote
	int sh_pan[4];
	int sh_mvol;

	mix_sample_t stim_q[$];
	logic signed [OUT_W-1:0] exp_l[$], exp_r[$], got_l[$], got_r[$];
	int exp_cyc[$], got_cyc[$];

	fm_mixer_top #(.OSCS(4)) DUT (.*);

	always #20 sCLK_XVXENVS = ~sCLK_XVXENVS;

	always @(posedge sCLK_XVXENVS) cyc <= cyc + 1;

	// x^17 + x^14 + 1
	function automatic logic next_rand_bit();
		logic b;
		b = lfsr_state[16] ^ lfsr_state[13];
		lfsr_state = {lfsr_state[15:0], b};
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_rand_bit()};
		return v;
	endfunction

	function automatic logic signed [OUT_W-1:0] clip16(input longint v);
		if (v > 32767)
			return 16'sh7fff;
		if (v < -32768)
			return 16'sh8000;
		return v[15:0];
	endfunction

	// expected stereo word of stim_q[first .. first+cnt-1]
	function automatic void model_frame(input int first, input int cnt,
			output logic signed [OUT_W-1:0] l, output logic signed [OUT_W-1:0] r);
		longint sl, sr, v;
		sl = 0;
		sr = 0;
		for (int i = first; i < first + cnt; i++) begin
			v = longint'(stim_q[i].lvl) * longint'(stim_q[i].sine);
			v = v * sh_lvl[stim_q[i].osc];
			sl += v * (127 - sh_pan[stim_q[i].osc]);
			sr += v * sh_pan[stim_q[i].osc];
		end
		l = clip16((sl * sh_mvol) >>> OUT_SHIFT);
		r = clip16((sr * sh_mvol) >>> OUT_SHIFT);
	endfunction

	task automatic write_reg(input reg_bank_e b, input int a, input logic [7:0] d);
		@(negedge sCLK_XVXENVS);
		bank  = b;
		adr   = a[ADR_W-1:0];
		wdata = d;
		write = 1'b1;
		@(negedge sCLK_XVXENVS);
		write = 1'b0;
		if (b == BANK_COM && a == REG_M_VOL)
			sh_mvol = int'($signed(d));
		else if (b == BANK_OSC && a < 64 && a % 16 == REG_OSC_LVL)
			sh_lvl[a / 16] = int'($signed(d));
		else if (b == BANK_OSC && a < 64 && a % 16 == REG_OSC_PAN)
			sh_pan[a / 16] = int'($signed(d));
	endtask

	task automatic check_reg(input reg_bank_e b, input int a, input logic [7:0] exp);
		@(negedge sCLK_XVXENVS);
		bank = b;
		adr  = a[ADR_W-1:0];
		read = 1'b1;
		@(negedge sCLK_XVXENVS);
		read = 1'b0;
		if (rdata !== exp) begin
			$display("MISMATCH at %0t: rdata (bank %0d adr %0d) got %h expected %h",
				$time, b, a, rdata, exp);
			err_mismatch++;
		end
	endtask

	task automatic add_sample(input int osc, input int lvl, input int sine, input logic last);
		mix_sample_t s;
		s.osc  = osc[1:0];
		s.lvl  = lvl[7:0];
		s.sine = sine[16:0];
		s.last = last;
		stim_q.push_back(s);
	endtask

	// drive stim_q back to back and collect one output per frame
	task automatic play_frames();
		int first;
		int nfr;
		int waited;
		logic signed [OUT_W-1:0] l, r;
		first = 0;
		foreach (stim_q[i]) begin
			if (stim_q[i].last) begin
				model_frame(first, i - first + 1, l, r);
				exp_l.push_back(l);
				exp_r.push_back(r);
				first = i + 1;
			end
		end
		nfr = exp_l.size();
		fork
			begin
				foreach (stim_q[i]) begin
					@(negedge sCLK_XVXENVS);
					sample_en = 1'b1;
					sample    = stim_q[i];
					if (stim_q[i].last)
						exp_cyc.push_back(cyc + 6); // sampling edge plus 5
				end
				@(negedge sCLK_XVXENVS);
				sample_en = 1'b0;
			end
			begin
				waited = 0;
				while (got_l.size() < nfr && waited < 100) begin
					@(negedge sCLK_XVXENVS);
					waited++;
					if (out_valid) begin
						got_l.push_back(lsound_out);
						got_r.push_back(rsound_out);
						got_cyc.push_back(cyc);
					end
				end
			end
		join
		if (got_l.size() < nfr) begin
			$display("ERROR at %0t: timed out, only %0d of %0d frames produced out_valid",
				$time, got_l.size(), nfr);
			err_timeout++;
		end
		for (int i = 0; i < got_l.size(); i++) begin
			if (got_l[i] !== exp_l[i]) begin
				$display("MISMATCH at %0t: lsound_out got %0d expected %0d",
					$time, got_l[i], exp_l[i]);
				err_mismatch++;
			end
			if (got_r[i] !== exp_r[i]) begin
				$display("MISMATCH at %0t: rsound_out got %0d expected %0d",
					$time, got_r[i], exp_r[i]);
				err_mismatch++;
			end
			if (got_cyc[i] != exp_cyc[i]) begin
				$display("MISMATCH at %0t: out_valid cycle got %0d expected %0d",
					$time, got_cyc[i], exp_cyc[i]);
				err_mismatch++;
			end
		end
	endtask

	task automatic clear_frames();
		stim_q.delete();
		exp_l.delete();
		exp_r.delete();
		exp_cyc.delete();
		got_l.delete();
		got_r.delete();
		got_cyc.delete();
	endtask

	task automatic read_reset_defaults();
		for (int o = 0; o < 4; o++) begin
			check_reg(BANK_OSC, o * 16 + REG_OSC_LVL, (o <= 1) ? 8'h40 : 8'h00);
			check_reg(BANK_OSC, o * 16 + REG_OSC_PAN, 8'h40);
		end
		check_reg(BANK_COM, REG_M_VOL, 8'h40);
		check_reg(BANK_OSC, 0, 8'h00);
		check_reg(BANK_OSC, 4 * 16 + REG_OSC_LVL, 8'h00); // osc index beyond OSCS
		check_reg(BANK_COM, 0, 8'h00);
		check_reg(BANK_COM, 5, 8'h00);
	endtask

	task automatic reg_write_readback();
		for (int o = 0; o < 4; o++) begin
			write_reg(BANK_OSC, o * 16 + REG_OSC_LVL, rand_bits(8));
			write_reg(BANK_OSC, o * 16 + REG_OSC_PAN, rand_bits(7)); // keep pan in 0..127
		end
		write_reg(BANK_COM, REG_M_VOL, rand_bits(8));
		write_reg(BANK_OSC, 3, 8'hA5);  // unmapped
		write_reg(BANK_COM, 9, 8'h5A);
		for (int o = 0; o < 4; o++) begin
			check_reg(BANK_OSC, o * 16 + REG_OSC_LVL, sh_lvl[o][7:0]);
			check_reg(BANK_OSC, o * 16 + REG_OSC_PAN, sh_pan[o][7:0]);
		end
		check_reg(BANK_COM, REG_M_VOL, sh_mvol[7:0]);
		check_reg(BANK_OSC, 3, 8'h00);
		check_reg(BANK_COM, 9, 8'h00);
	endtask

	task automatic single_frame_mix();
		clear_frames();
		for (int o = 0; o < 4; o++)
			add_sample(o, rand_bits(8), $signed(rand_bits(17)), o == 3);
		play_frames();
	endtask

	task automatic pan_and_volume();
		write_reg(BANK_OSC, 0 * 16 + REG_OSC_LVL, 8'h40);
		write_reg(BANK_OSC, 1 * 16 + REG_OSC_LVL, 8'h40);
		write_reg(BANK_OSC, 0 * 16 + REG_OSC_PAN, 8'd0);   // hard left
		write_reg(BANK_OSC, 1 * 16 + REG_OSC_PAN, 8'd127); // hard right
		write_reg(BANK_COM, REG_M_VOL, 8'h40);
		clear_frames();
		add_sample(0, 100, 30000, 1'b1);
		add_sample(1, 100, 30000, 1'b1);
		play_frames();
		if (got_l.size() == 2 && (got_r[0] !== 0 || got_l[1] !== 0 || got_l[0] == 0)) begin
			$display("ERROR at %0t: pan did not steer the signal to one side", $time);
			err_mismatch++;
		end
		write_reg(BANK_COM, REG_M_VOL, 8'h20); // half volume
		clear_frames();
		add_sample(0, 100, 30000, 1'b1);
		add_sample(1, 100, -30000, 1'b1);
		play_frames();
	endtask

	task automatic saturation_clip();
		for (int o = 0; o < 4; o++) begin
			write_reg(BANK_OSC, o * 16 + REG_OSC_LVL, 8'd127);
			write_reg(BANK_OSC, o * 16 + REG_OSC_PAN, 8'd64);
		end
		write_reg(BANK_COM, REG_M_VOL, 8'd127);
		clear_frames();
		for (int o = 0; o < 4; o++)
			add_sample(o, 127, 65535, o == 3);
		for (int o = 0; o < 4; o++)
			add_sample(o, 127, -65536, o == 3);
		play_frames();
		if (got_l.size() == 2 && (got_l[0] !== 16'sh7fff || got_r[0] !== 16'sh7fff ||
				got_l[1] !== 16'sh8000 || got_r[1] !== 16'sh8000)) begin
			$display("ERROR at %0t: outputs did not clip to the 16-bit limits", $time);
			err_mismatch++;
		end
	endtask

	task automatic back_to_back_frames();
		for (int o = 0; o < 4; o++) begin
			write_reg(BANK_OSC, o * 16 + REG_OSC_LVL, rand_bits(8));
			write_reg(BANK_OSC, o * 16 + REG_OSC_PAN, rand_bits(7));
		end
		write_reg(BANK_COM, REG_M_VOL, 8'h30);
		clear_frames();
		for (int o = 0; o < 4; o++)
			add_sample(o, rand_bits(8), $signed(rand_bits(17)), o == 3);
		add_sample(2, rand_bits(8), $signed(rand_bits(17)), 1'b1); // one-sample frame
		for (int o = 0; o < 3; o++)
			add_sample(o, rand_bits(8), $signed(rand_bits(17)), o == 2);
		play_frames();
	endtask

	initial begin
		sCLK_XVXENVS = 1'b0;
		reset_data_N = 1'b0;
		sample_en    = 1'b0;
		sample       = '0;
		bank         = BANK_OSC;
		adr          = '0;
		wdata        = '0;
		write        = 1'b0;
		read         = 1'b0;
		cyc          = 0;
		err_mismatch = 0;
		err_timeout  = 0;
		lfsr_state   = 17'd72754;
		for (int o = 0; o < 4; o++) begin
			sh_lvl[o] = (o <= 1) ? 64 : 0;
			sh_pan[o] = 64;
		end
		sh_mvol = 64;
		repeat (4) @(negedge sCLK_XVXENVS);
		reset_data_N = 1'b1;

		read_reset_defaults();
		reg_write_readback();
		single_frame_mix();
		pan_and_volume();
		saturation_clip();
		back_to_back_frames();

		$display("errors: %0d mismatches, %0d timeouts", err_mismatch, err_timeout);
		if (err_mismatch == 0 && err_timeout == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fm_mixer_top.f ====
src/mix_cfg_pkg.sv
src/mix_types_pkg.sv
src/patch_regs.sv
src/osc_scaler.sv
src/frame_mixer.sv
src/fm_mixer_top.sv
tests/fm_mixer_chk.sv
tests/tb_fm_mixer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fm_mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f fm_mixer_top.f --top-module tb_fm_mixer -o tb_fm_mixer > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	cat build.log
	exit 1
fi

./obj_dir/tb_fm_mixer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
